/* rtl/ledmat_pkg.sv */
package ledmat_pkg;

    // Panel geometry
    localparam int panel_width = 16;
    localparam int panel_height = 8;
    localparam int half_height = panel_height / 2; // Rows r and r+4 are driven together
    localparam int fb_depth = panel_width * panel_height;

    // Brightness planes and their display weights
    localparam int plane_bits = 4;
    localparam int oe_base_cycles = 8; // Plane p shows for oe_base_cycles << p

    typedef logic [$clog2(fb_depth)-1:0] fb_addr_t; // row * 16 + column
    typedef logic [15:0] rgb565_t;
    typedef logic [$clog2(plane_bits)-1:0] plane_t;
    typedef logic [$clog2(panel_width)-1:0] col_t;
    typedef logic [$clog2(half_height)-1:0] row_t;

    // MSB of each RGB565 field
    localparam int red_top = 15;
    localparam int green_top = 10;
    localparam int blue_top = 4;

    // Plane p of a channel is bit (top - 3 + p) of its field, so plane 3 is the MSB.
    // Result bit 0 is red, bit 1 green, bit 2 blue.
    function automatic logic [2:0] split_plane(rgb565_t px, plane_t plane);
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
        red = px[red_top -: 4];
        green = px[green_top -: 4];
        blue = px[blue_top -: 4];
        return {blue[plane], green[plane], red[plane]};
    endfunction

endpackage

/* rtl/fb_mem_if.sv */
`timescale 1ns/1ps

// One client's four-phase port onto the frame RAM
interface fb_mem_if;
    logic req;
    logic we;
    ledmat_pkg::fb_addr_t addr;
    ledmat_pkg::rgb565_t wdata;
    logic ack;
    ledmat_pkg::rgb565_t rdata; // Valid while ack is high on a read

    modport client (
        output req, we, addr, wdata,
        input ack, rdata
    );

    modport arbiter (
        input req, we, addr, wdata,
        output ack, rdata
    );
endinterface

/* rtl/pixel_req_if.sv */
`timescale 1ns/1ps

interface pixel_req_if;
    logic req;
    ledmat_pkg::col_t col;
    ledmat_pkg::row_t row;     // Row pair, bottom row is row + 4
    ledmat_pkg::plane_t plane;
    logic ack;
    logic [2:0] rgb_top;       // Bit 0 red, bit 1 green, bit 2 blue
    logic [2:0] rgb_bottom;

    modport scan (output req, col, row, plane, input ack, rgb_top, rgb_bottom);
    modport fetch (input req, col, row, plane, output ack, rgb_top, rgb_bottom);
endinterface

/* rtl/frame_ram.sv */
`timescale 1ns/1ps

module frame_ram (
    input  logic                 clk_root,
    input  logic                 en,
    input  logic                 we,
    input  ledmat_pkg::fb_addr_t addr,
    input  ledmat_pkg::rgb565_t  wdata,
    output ledmat_pkg::rgb565_t  rdata
);

    ledmat_pkg::rgb565_t mem [ledmat_pkg::fb_depth];

    // Single port, read data one cycle after the access
    always_ff @(posedge clk_root) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

/* rtl/fb_arbiter.sv */
`timescale 1ns/1ps

module fb_arbiter (
    input  logic                 clk_root,
    input  logic                 rst,
    fb_mem_if.arbiter            fetch,
    fb_mem_if.arbiter            load,
    output logic                 ram_en,
    output logic                 ram_we,
    output ledmat_pkg::fb_addr_t ram_addr,
    output ledmat_pkg::rgb565_t  ram_wdata,
    input  ledmat_pkg::rgb565_t  ram_rdata
);

    typedef enum logic [1:0] {st_idle, st_access, st_respond, st_release} arb_state_t;

    arb_state_t state;
    logic sel_fetch;            // Owner of the current grant
    logic sel_req;
    logic ack_q;
    ledmat_pkg::rgb565_t rdata_q;

    assign sel_req = sel_fetch ? fetch.req : load.req;

    // RAM is driven by the granted client only during the access cycle
    assign ram_en = (state == st_access);
    assign ram_we = sel_fetch ? fetch.we : load.we;
    assign ram_addr = sel_fetch ? fetch.addr : load.addr;
    assign ram_wdata = sel_fetch ? fetch.wdata : load.wdata;

    assign fetch.ack = ack_q & sel_fetch;
    assign load.ack = ack_q & ~sel_fetch;
    assign fetch.rdata = rdata_q;
    assign load.rdata = rdata_q;

    always_ff @(posedge clk_root) begin
        if (rst) begin
            state <= st_idle;
            sel_fetch <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (fetch.req) begin        // Display timing comes first
                        sel_fetch <= 1'b1;
                        state <= st_access;
                    end else if (load.req) begin
                        sel_fetch <= 1'b0;
                        state <= st_access;
                    end
                end
                st_access: begin
                    if (ram_we) begin
                        ack_q <= 1'b1;          // Write is done at this edge
                        state <= st_release;
                    end else begin
                        state <= st_respond;
                    end
                end
                st_respond: begin
                    ack_q <= 1'b1;
                    state <= st_release;
                end
                default: begin
                    if (!sel_req) begin
                        ack_q <= 1'b0;
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_root) begin
        if (state == st_respond) begin
            rdata_q <= ram_rdata;
        end
    end

    a_fetch_ack_on_req: assert property (@(posedge clk_root) disable iff (rst)
        $rose(fetch.ack) |-> fetch.req);
    a_load_ack_on_req: assert property (@(posedge clk_root) disable iff (rst)
        $rose(load.ack) |-> load.req);
    a_fetch_addr_hold: assert property (@(posedge clk_root) disable iff (rst)
        fetch.req && !fetch.ack |=> $stable(fetch.addr));
    a_load_addr_hold: assert property (@(posedge clk_root) disable iff (rst)
        load.req && !load.ack |=> $stable(load.addr));

endmodule

/* rtl/pixel_loader.sv */
`timescale 1ns/1ps

module pixel_loader (
    input  logic       clk_root,
    input  logic       rst,
    input  logic       rx_req,
    input  logic       rx_sof,
    input  logic [7:0] rx_data,
    output logic       rx_ack,
    fb_mem_if.client   mem
);

    logic phase_hi;             // Next byte is the high byte
    logic accept;
    logic low_byte;
    ledmat_pkg::fb_addr_t wr_addr;
    ledmat_pkg::rgb565_t pix_q;

    // No new byte while a write is still in flight
    assign accept = rx_req && !rx_ack && !mem.req && !mem.ack;
    assign low_byte = rx_sof || !phase_hi;

    assign mem.we = 1'b1;
    assign mem.addr = wr_addr;
    assign mem.wdata = pix_q;

    always_ff @(posedge clk_root) begin
        if (rst) begin
            rx_ack <= 1'b0;
            phase_hi <= 1'b0;
            wr_addr <= '0;
            mem.req <= 1'b0;
        end else begin
            if (rx_ack && !rx_req) begin
                rx_ack <= 1'b0;
            end
            if (accept) begin
                if (low_byte) begin
                    phase_hi <= 1'b1;
                    rx_ack <= 1'b1;
                    if (rx_sof) begin
                        wr_addr <= '0;  // New frame starts at pixel 0
                    end
                end else begin
                    phase_hi <= 1'b0;
                    mem.req <= 1'b1;    // High byte is acked after the write
                end
            end
            if (mem.req && mem.ack) begin
                mem.req <= 1'b0;
                rx_ack <= 1'b1;
                wr_addr <= wr_addr + 7'd1; // Wraps 127 -> 0
            end
        end
    end

    always_ff @(posedge clk_root) begin
        if (accept) begin
            if (low_byte) begin
                pix_q[7:0] <= rx_data;
            end else begin
                pix_q[15:8] <= rx_data;
            end
        end
    end

    // A new byte is never offered while a RAM write is still outstanding
    a_no_byte_in_write: assert property (@(posedge clk_root) disable iff (rst)
        $rose(rx_req) |-> !mem.req);

endmodule

/* rtl/pixel_fetch.sv */
`timescale 1ns/1ps

module pixel_fetch (
    input logic        clk_root,
    input logic        rst,
    pixel_req_if.fetch pix,
    fb_mem_if.client   mem
);

    typedef enum logic [2:0] {
        st_idle,
        st_rd_top,
        st_gap,
        st_rd_bot,
        st_done
    } fetch_state_t;

    fetch_state_t state;
    logic bottom_sel;
    logic [2:0] top_q;
    logic [2:0] bot_q;

    assign bottom_sel = (state == st_gap) || (state == st_rd_bot);

    // Top pixel at row r, bottom at r + 4
    assign mem.addr = {bottom_sel, pix.row, pix.col};
    assign mem.we = 1'b0;
    assign mem.wdata = '0;

    assign pix.rgb_top = top_q;
    assign pix.rgb_bottom = bot_q;

    always_ff @(posedge clk_root) begin
        if (rst) begin
            state <= st_idle;
            mem.req <= 1'b0;
            pix.ack <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (pix.req && !pix.ack && !mem.ack) begin
                        mem.req <= 1'b1;
                        state <= st_rd_top;
                    end
                end
                st_rd_top: begin
                    if (mem.ack) begin
                        mem.req <= 1'b0;
                        state <= st_gap;
                    end
                end
                st_gap: begin
                    if (!mem.ack) begin  // Wait for the arbiter to release
                        mem.req <= 1'b1;
                        state <= st_rd_bot;
                    end
                end
                st_rd_bot: begin
                    if (mem.ack) begin
                        mem.req <= 1'b0;
                        pix.ack <= 1'b1;
                        state <= st_done;
                    end
                end
                default: begin
                    if (!pix.req) begin
                        pix.ack <= 1'b0;
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_root) begin
        if (mem.req && mem.ack) begin
            if (bottom_sel) begin
                bot_q <= ledmat_pkg::split_plane(mem.rdata, pix.plane);
            end else begin
                top_q <= ledmat_pkg::split_plane(mem.rdata, pix.plane);
            end
        end
    end

endmodule

/* rtl/matrix_scan.sv */
`timescale 1ns/1ps

module matrix_scan (
    input  logic             clk_root,
    input  logic             rst,
    pixel_req_if.scan        pix,
    output logic             clk_pixel,
    output logic             row_latch,
    output logic             output_enable,
    output ledmat_pkg::row_t row_addr,
    output logic [2:0]       rgb_top,
    output logic [2:0]       rgb_bottom
);

    typedef enum logic [1:0] {st_shift, st_latch, st_display} scan_state_t;

    scan_state_t state;
    ledmat_pkg::col_t col;
    ledmat_pkg::row_t row;
    ledmat_pkg::plane_t plane;
    logic [6:0] oe_cnt;         // Up to 64 cycles for plane 3
    logic row_full;             // All 16 columns fetched
    logic load_d;               // rgb loaded last cycle
    logic pix_done;

    assign pix.col = col;
    assign pix.row = row;
    assign pix.plane = plane;
    assign pix_done = pix.req && pix.ack;

    always_ff @(posedge clk_root) begin
        if (rst) begin
            state <= st_shift;
            col <= '0;
            row <= '0;
            plane <= '0;
            oe_cnt <= '0;
            row_full <= 1'b0;
            load_d <= 1'b0;
            clk_pixel <= 1'b0;
            row_latch <= 1'b0;
            output_enable <= 1'b0;
            row_addr <= '0;
            pix.req <= 1'b0;
        end else begin
            load_d <= pix_done;
            clk_pixel <= load_d;    // One-cycle pulse after the rgb load
            row_latch <= 1'b0;
            case (state)
                st_shift: begin
                    if (pix_done) begin
                        pix.req <= 1'b0;
                        col <= col + 4'd1;
                        if (col == ledmat_pkg::col_t'(ledmat_pkg::panel_width - 1)) begin
                            row_full <= 1'b1;
                        end
                    end else if (!row_full && !pix.req && !pix.ack) begin
                        pix.req <= 1'b1;    // May overlap the clk_pixel pulse
                    end
                    if (row_full && clk_pixel) begin
                        row_latch <= 1'b1;
                        row_addr <= row;
                        state <= st_latch;
                    end
                end
                st_latch: begin
                    output_enable <= 1'b1;
                    oe_cnt <= 7'((ledmat_pkg::oe_base_cycles << plane) - 1);
                    state <= st_display;
                end
                default: begin
                    if (oe_cnt == '0) begin
                        output_enable <= 1'b0;
                        row_full <= 1'b0;
                        row <= row + 2'd1;
                        // Plane is the outer loop
                        if (row == ledmat_pkg::row_t'(ledmat_pkg::half_height - 1)) begin
                            plane <= plane + 2'd1;
                        end
                        state <= st_shift;
                    end else begin
                        oe_cnt <= oe_cnt - 7'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_root) begin
        if (pix_done) begin
            rgb_top <= pix.rgb_top;
            rgb_bottom <= pix.rgb_bottom;
        end
    end

    a_oe_clk_excl: assert property (@(posedge clk_root) disable iff (rst)
        !(output_enable && clk_pixel));

endmodule

/* rtl/led_matrix_top.sv */
`timescale 1ns/1ps

module led_matrix_top (
    input  logic       clk_root,
    input  logic       rst,
    input  logic       rx_req,
    input  logic       rx_sof,
    input  logic [7:0] rx_data,
    output logic       rx_ack,
    output logic       clk_pixel,
    output logic       row_latch,
    output logic       output_enable_n,
    output logic [1:0] row_addr,
    output logic [2:0] rgb_top,
    output logic [2:0] rgb_bottom
);

    fb_mem_if fetch_mem ();
    fb_mem_if load_mem ();
    pixel_req_if pix_req ();

    logic ram_en;
    logic ram_we;
    ledmat_pkg::fb_addr_t ram_addr;
    ledmat_pkg::rgb565_t ram_wdata;
    ledmat_pkg::rgb565_t ram_rdata;
    logic output_enable;

    frame_ram frame_ram_i (
        .clk_root(clk_root),
        .en(ram_en),
        .we(ram_we),
        .addr(ram_addr),
        .wdata(ram_wdata),
        .rdata(ram_rdata)
    );

    fb_arbiter fb_arbiter_i (
        .clk_root(clk_root),
        .rst(rst),
        .fetch(fetch_mem.arbiter),
        .load(load_mem.arbiter),
        .ram_en(ram_en),
        .ram_we(ram_we),
        .ram_addr(ram_addr),
        .ram_wdata(ram_wdata),
        .ram_rdata(ram_rdata)
    );

    pixel_loader pixel_loader_i (
        .clk_root(clk_root),
        .rst(rst),
        .rx_req(rx_req),
        .rx_sof(rx_sof),
        .rx_data(rx_data),
        .rx_ack(rx_ack),
        .mem(load_mem.client)
    );

    pixel_fetch pixel_fetch_i (
        .clk_root(clk_root),
        .rst(rst),
        .pix(pix_req.fetch),
        .mem(fetch_mem.client)
    );

    matrix_scan matrix_scan_i (
        .clk_root(clk_root),
        .rst(rst),
        .pix(pix_req.scan),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .output_enable(output_enable),
        .row_addr(row_addr),
        .rgb_top(rgb_top),
        .rgb_bottom(rgb_bottom)
    );

    assign output_enable_n = ~output_enable; // Panel OE pin is active low

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_root,
    output logic rst
);

    initial begin
        clk_root = 1'b0;
        forever #5 clk_root = ~clk_root; // 10 ns period
    end

    // Reset held over the first three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk_root);
        #1 rst = 1'b0;
    end

endmodule

/* tests/led_matrix_tb.sv */
`timescale 1ns/1ps

module led_matrix_tb;

    localparam int rows_per_frame = ledmat_pkg::plane_bits * ledmat_pkg::half_height;
    localparam int frame_cycles = 16 * (16 * 8 + 120);
    localparam int num_tests = 6;
    localparam int load_margin = 808 * 20;  // Every byte sent, at 20 cycles each
    localparam int timeout_cycles = num_tests * 2 * frame_cycles + load_margin;

    logic clk_root;
    logic rst;
    logic rx_req;
    logic rx_sof;
    logic [7:0] rx_data;
    logic rx_ack;
    logic clk_pixel;
    logic row_latch;
    logic output_enable_n;
    logic [1:0] row_addr;
    logic [2:0] rgb_top;
    logic [2:0] rgb_bottom;

    // Reference image and the loader's expected write pointer
    logic [15:0] ref_img [ledmat_pkg::fb_depth];
    int model_addr = 0;
    int bytes_sent = 0;
    int err_count = 0;
    int mon_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count;

    // Panel monitor state
    logic [2:0] top_buf [16];
    logic [2:0] bot_buf [16];
    logic [2:0] pend_top [16];
    logic [2:0] pend_bot [16];
    logic [2:0] rec_top [16];
    logic [2:0] rec_bot [16];
    logic [2:0] top_d;
    logic [2:0] bot_d;
    logic [1:0] pend_row;
    logic [1:0] rec_row;
    int pix_cnt;
    int pend_pix;
    int rec_pix;
    int oe_cnt;
    int rec_oe;
    int rec_total;
    int ack_rises;
    logic in_display;
    logic ack_d;
    logic req_d;

    tb_clock_gen clock_gen_i (.clk_root(clk_root), .rst(rst));

    led_matrix_top dut_i (
        .clk_root(clk_root),
        .rst(rst),
        .rx_req(rx_req),
        .rx_sof(rx_sof),
        .rx_data(rx_data),
        .rx_ack(rx_ack),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .output_enable_n(output_enable_n),
        .row_addr(row_addr),
        .rgb_top(rgb_top),
        .rgb_bottom(rgb_bottom)
    );

    // Collects one record per row, finished when output enable goes inactive again
    always @(posedge clk_root) begin
        if (rst) begin
            pix_cnt <= 0;
            oe_cnt <= 0;
            rec_total <= 0;
            in_display <= 1'b0;
            ack_d <= 1'b0;
            req_d <= 1'b0;
            ack_rises = 0;
        end else begin
            ack_d <= rx_ack;
            req_d <= rx_req;
            top_d <= rgb_top;
            bot_d <= rgb_bottom;
            if (rx_ack && !ack_d) begin
                ack_rises = ack_rises + 1;
            end
            if (ack_d && !rx_ack && req_d) begin
                $display("rx_ack dropped while rx_req was still high at %0t", $time);
                mon_errors = mon_errors + 1;
            end
            if (clk_pixel) begin
                if (!output_enable_n) begin
                    $display("clk_pixel pulsed during output enable at %0t", $time);
                    mon_errors = mon_errors + 1;
                end
                if (pix_cnt < 16) begin
                    top_buf[pix_cnt] <= top_d; // Lines as they stood when clk_pixel rose
                    bot_buf[pix_cnt] <= bot_d;
                end
                pix_cnt <= pix_cnt + 1;
            end
            if (row_latch) begin
                pend_row <= row_addr;
                pend_pix <= pix_cnt;
                pend_top <= top_buf;
                pend_bot <= bot_buf;
                pix_cnt <= 0;
                oe_cnt <= 0;
                in_display <= 1'b1;
            end
            if (!output_enable_n) begin
                if (!in_display) begin
                    $display("Output enable active outside the display window at %0t", $time);
                    mon_errors = mon_errors + 1;
                end
                oe_cnt <= oe_cnt + 1;
            end else if (in_display && oe_cnt != 0) begin
                rec_row <= pend_row;
                rec_pix <= pend_pix;
                rec_top <= pend_top;
                rec_bot <= pend_bot;
                rec_oe <= oe_cnt;
                in_display <= 1'b0;
                rec_total <= rec_total + 1;
            end
        end
    end

    // Plane p of each channel is bit (field MSB - 3 + p); bit 0 red, 1 green, 2 blue
    function automatic logic [2:0] expected_rgb(input logic [15:0] px, input int plane);
        expected_rgb = {px[1 + plane], px[7 + plane], px[12 + plane]};
    endfunction

    task automatic send_byte(input logic [7:0] data, input logic sof);
        @(posedge clk_root);
        #1;
        rx_data = data;
        rx_sof = sof;
        rx_req = 1'b1;
        do begin
            @(posedge clk_root);
            #1;
        end while (!rx_ack);
        rx_req = 1'b0;
        rx_sof = 1'b0;
        do begin
            @(posedge clk_root);
            #1;
        end while (rx_ack);
        bytes_sent++;
    endtask

    // Low byte first; a start of frame sends the write pointer back to pixel 0
    task automatic send_pixel(input logic [15:0] px, input logic sof);
        if (sof) begin
            model_addr = 0;
        end
        ref_img[model_addr] = px;
        model_addr = (model_addr + 1) % ledmat_pkg::fb_depth;
        send_byte(px[7:0], sof);
        send_byte(px[15:8], 1'b0);
    endtask

    task automatic wait_record();
        int start;
        start = rec_total;
        while (rec_total == start) begin
            @(posedge clk_root);
            #1;
        end
    endtask

    // Record 15 of a frame is plane 3, row pair 3
    task automatic skip_to_frame_end();
        do begin
            wait_record();
        end while ((rec_total - 1) % rows_per_frame != rows_per_frame - 1);
    endtask

    task automatic compare_frame(input string name);
        int idx;
        int plane;
        int row;
        logic [2:0] exp_top;
        logic [2:0] exp_bot;
        skip_to_frame_end();      // Every row after this is fetched from the new image
        for (int k = 0; k < rows_per_frame; k++) begin
            wait_record();
            idx = rec_total - 1;
            plane = (idx / ledmat_pkg::half_height) % ledmat_pkg::plane_bits;
            row = idx % ledmat_pkg::half_height;
            if (rec_row !== ledmat_pkg::row_t'(row)) begin
                $display("** Error %s: row_addr expected %0d actual %0d", name, row, rec_row);
                err_count++;
            end
            if (rec_pix != 16) begin
                $display("** Error %s: pixel count expected 16 actual %0d", name, rec_pix);
                err_count++;
            end
            for (int c = 0; c < 16; c++) begin
                exp_top = expected_rgb(ref_img[row * 16 + c], plane);
                exp_bot = expected_rgb(ref_img[(row + 4) * 16 + c], plane);
                if (rec_top[c] !== exp_top) begin
                    $display("** Error %s: plane %0d row %0d col %0d top expected %b actual %b",
                             name, plane, row, c, exp_top, rec_top[c]);
                    err_count++;
                end
                if (rec_bot[c] !== exp_bot) begin
                    $display("** Error %s: plane %0d row %0d col %0d bottom expected %b actual %b",
                             name, plane, row + 4, c, exp_bot, rec_bot[c]);
                    err_count++;
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int start);
        int n;
        n = err_count + mon_errors - start;
        tests_run++;
        if (n != 0) begin
            tests_failed++;
        end
        $display("%s: %s, %0d errors", name, (n == 0) ? "ok" : "failed", n);
    endtask

    task automatic reset_state();
        int start;
        start = err_count + mon_errors;
        @(posedge clk_root);
        #1;
        while (rst) begin
            if (clk_pixel !== 1'b0 || row_latch !== 1'b0 || output_enable_n !== 1'b1 ||
                rx_ack !== 1'b0) begin
                $display("Panel or byte port outputs not idle during reset at %0t", $time);
                err_count++;
            end
            @(posedge clk_root);
            #1;
        end
        if (clk_pixel !== 1'b0 || row_latch !== 1'b0 || output_enable_n !== 1'b1 ||
            rx_ack !== 1'b0) begin
            $display("Panel or byte port outputs not idle right after reset");
            err_count++;
        end
        wait_record();
        if (rec_row !== 2'd0) begin
            $display("** Error reset_state: first row expected 0 actual %0d", rec_row);
            err_count++;
        end
        if (rec_oe != ledmat_pkg::oe_base_cycles) begin
            $display("** Error reset_state: first OE length expected %0d actual %0d",
                     ledmat_pkg::oe_base_cycles, rec_oe);
            err_count++;
        end
        report_test("reset_state", start);
    endtask

    task automatic solid_colour();
        int start;
        start = err_count + mon_errors;
        for (int i = 0; i < ledmat_pkg::fb_depth; i++) begin
            send_pixel(16'hb59a, i == 0);
        end
        compare_frame("solid_colour");
        report_test("solid_colour", start);
    endtask

    // Loading overlaps the scan, so the arbiter and loader back-pressure are exercised
    task automatic random_image();
        int start;
        start = err_count + mon_errors;
        for (int i = 0; i < ledmat_pkg::fb_depth; i++) begin
            send_pixel(16'($urandom), i == 0);
        end
        compare_frame("random_image");
        report_test("random_image", start);
    endtask

    task automatic plane_weighting();
        int start;
        int plane;
        int expected;
        start = err_count + mon_errors;
        for (int k = 0; k < rows_per_frame; k++) begin
            wait_record();
            plane = ((rec_total - 1) / ledmat_pkg::half_height) % ledmat_pkg::plane_bits;
            expected = ledmat_pkg::oe_base_cycles << plane;
            if (rec_oe != expected) begin
                $display("** Error plane_weighting: plane %0d OE cycles expected %0d actual %0d",
                         plane, expected, rec_oe);
                err_count++;
            end
        end
        report_test("plane_weighting", start);
    endtask

    task automatic frame_restart();
        int start;
        start = err_count + mon_errors;
        for (int i = 0; i < 20; i++) begin
            send_pixel(16'($urandom), 1'b0);     // 40 bytes, pointer left at pixel 20
        end
        for (int i = 0; i < ledmat_pkg::fb_depth; i++) begin
            send_pixel(16'($urandom), i == 0);
        end
        compare_frame("frame_restart");
        report_test("frame_restart", start);
    endtask

    task automatic handshake_integrity();
        int start;
        start = err_count + mon_errors;
        if (ack_rises != bytes_sent) begin
            $display("** Error handshake_integrity: acks expected %0d actual %0d",
                     bytes_sent, ack_rises);
            err_count++;
        end
        if (rx_ack !== 1'b0) begin
            $display("rx_ack still high with no byte pending");
            err_count++;
        end
        report_test("handshake_integrity", start);
    endtask

    initial begin
        for (cycle_count = 0; cycle_count < timeout_cycles; cycle_count++) begin
            @(posedge clk_root);
        end
        $display("Timeout after %0d cycles, the tests did not finish", timeout_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rx_req = 1'b0;
        rx_sof = 1'b0;
        rx_data = '0;
        void'($urandom(32'h1d1c));
        reset_state();
        solid_colour();
        random_image();
        plane_weighting();
        frame_restart();
        handshake_integrity();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 err_count + mon_errors);
        if (err_count + mon_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
rtl/ledmat_pkg.sv
rtl/fb_mem_if.sv
rtl/pixel_req_if.sv
rtl/frame_ram.sv
rtl/fb_arbiter.sv
rtl/pixel_loader.sv
rtl/pixel_fetch.sv
rtl/matrix_scan.sv
rtl/led_matrix_top.sv
tests/tb_clock_gen.sv
tests/led_matrix_tb.sv

/* Bender.yml */
package:
  name: led_matrix

sources:
  - rtl/ledmat_pkg.sv
  - rtl/fb_mem_if.sv
  - rtl/pixel_req_if.sv
  - rtl/frame_ram.sv
  - rtl/fb_arbiter.sv
  - rtl/pixel_loader.sv
  - rtl/pixel_fetch.sv
  - rtl/matrix_scan.sv
  - rtl/led_matrix_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/led_matrix_tb.sv
